//--- src/zports_pkg.sv
// zports shared definitions
`default_nettype none

package zports_pkg;

	// low address byte of each port
	localparam logic [7:0] PORT_FE    = 8'hFE; // keys, tape
	localparam logic [7:0] PORT_FD    = 8'hFD; // 128k paging, a15 low only
	localparam logic [7:0] PORT_XT    = 8'hAF; // extended regs, hoa picks one
	localparam logic [7:0] PORT_KJOY  = 8'h1F;
	localparam logic [7:0] PORT_SDCFG = 8'h77;
	localparam logic [7:0] PORT_SDDAT = 8'h57;

	// #nnAF register indices
	localparam logic [7:0] XT_STATUS  = 8'h00;
	localparam logic [7:0] XT_RAMPAGE = 8'h10; // #10..#13, one per window
	localparam logic [7:0] XT_FMADDR  = 8'h15;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;
	localparam logic [7:0] XT_FDDVIRT = 8'h29;
	localparam logic [7:0] XT_INTMASK = 8'h2A;

	// im2 vector source codes
	localparam logic [2:0] INT_FRM = 3'b000;
	localparam logic [2:0] INT_LIN = 3'b001;
	localparam logic [2:0] INT_DMA = 3'b010;

	localparam logic [7:0] SYSCONF_RST = 8'h01; // turbo 7 MHz
	localparam logic [7:0] MEMCONF_RST = 8'h04; // no map, 512k
	// page 3 first, so index i gives page i
	localparam logic [3:0][7:0] RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};
	localparam logic [2:0] IM2V_FRM_RST = 3'b111;
	localparam logic [7:0] INTMASK_RST  = 8'h01; // frame int only

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;    // 1 = write
	} cpu_bus_t;

	typedef struct packed {
		logic fe;
		logic xt;
		logic p7ffd;
		logic kjoy;   // dos low
		logic sdcfg;  // dos low
		logic sddat;  // dos low
	} port_sel_t;

	// one data byte as seen by 7FFD and by IM2VECT
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] page_hi;
			logic       lock48;
			logic       rom;
			logic       scr;
			logic [2:0] page_lo;
		} p7ffd;
		struct packed {
			logic       spare;
			logic [2:0] source;
			logic [2:0] vector;
			logic       low;
		} im2v;
	} data_byte_u;

endpackage

`default_nettype wire

//--- src/bus_handshake.sv
// four-phase access responder
`timescale 1ns/100ps
`default_nettype none

module bus_handshake
(
	input  wire  clk,
	input  wire  rst,
	input  wire  req,
	output logic ack,
	output logic acc_stb  // one cycle per access
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack     <= 1'b0;
			acc_stb <= 1'b0;
		end
		else
		begin
			// no new strobe while one is pending or ack still up
			acc_stb <= req & ~ack & ~acc_stb;

			if (acc_stb)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;  // requester has let go
		end
	end

	// ack follows a request that was still held
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req));

	stb_single: assert property (@(posedge clk) disable iff (rst)
		acc_stb |=> !acc_stb);

endmodule

`default_nettype wire

//--- src/port_decode.sv
// port address decode
`timescale 1ns/100ps
`default_nettype none

module port_decode
(
	input  wire [15:0]           addr,
	input  wire                  dos,
	output zports_pkg::port_sel_t sel,
	output logic                 porthit  // internal port hit
);

	import zports_pkg::*;

	logic [7:0] loa;

	assign loa = addr[7:0];

	always_comb
	begin
		sel.fe    = (loa == PORT_FE);
		sel.xt    = (loa == PORT_XT);
		sel.p7ffd = (loa == PORT_FD) && !addr[15]; // BFFD and up is not ours

		// hidden while the dos rom is on
		sel.kjoy  = (loa == PORT_KJOY) && !dos;
		sel.sdcfg = (loa == PORT_SDCFG) && !dos;
		sel.sddat = (loa == PORT_SDDAT) && !dos;
	end

	always_comb
	begin
		porthit = sel.fe
			| sel.xt
			| sel.p7ffd
			| sel.kjoy
			| sel.sdcfg
			| sel.sddat;
	end

endmodule

`default_nettype wire

//--- src/xt_regs.sv
// extended config registers and 7FFD paging
`timescale 1ns/100ps
`default_nettype none

module xt_regs
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      acc_stb,
	input  wire                      wr,
	input  wire zports_pkg::port_sel_t sel,
	input  wire [7:0]                hoa,
	input  wire zports_pkg::data_byte_u wdata,
	output logic [31:0]              xt_page,
	output logic [4:0]               fmaddr,
	output logic [7:0]               sysconf,
	output logic [7:0]               memconf,
	output logic [3:0]               fddvirt,
	output logic [2:0]               im2v_frm,
	output logic [2:0]               im2v_lin,
	output logic [2:0]               im2v_dma,
	output logic [7:0]               intmask,
	output logic                     pwr_up_flag
);

	import zports_pkg::*;

	logic [3:0][7:0] rampage;
	logic [7:0]      page3_nxt;
	logic            lock48;
	logic            pwr_up;  // set by reset, eaten by first status read

	wire xt_wr    = acc_stb & wr & sel.xt;
	wire p7ffd_wr = acc_stb & wr & sel.p7ffd & ~lock48;
	wire stat_rd  = acc_stb & ~wr & sel.xt & (hoa == XT_STATUS);

	assign xt_page = rampage;

	// page 3 from 7FFD, shaped by lock mode
	always_comb
	begin
		case (memconf[7:6])
			2'd0: page3_nxt = {3'b000, wdata.p7ffd.page_hi, wdata.p7ffd.page_lo};
			2'd3: page3_nxt = {2'b00, wdata.p7ffd.lock48, wdata.p7ffd.page_hi,
				wdata.p7ffd.page_lo};  // 1M paging
			default: page3_nxt = {5'b00000, wdata.p7ffd.page_lo}; // 128k only
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage  <= RAMPAGE_RST;
			fmaddr   <= '0;
			sysconf  <= SYSCONF_RST;
			memconf  <= MEMCONF_RST;
			fddvirt  <= '0;
			im2v_frm <= IM2V_FRM_RST;
			im2v_lin <= '0;
			im2v_dma <= '0;
			intmask  <= INTMASK_RST;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= wdata.p7ffd.rom;
			rampage[3] <= page3_nxt;
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == XT_RAMPAGE[7:2])
				rampage[hoa[1:0]] <= wdata.raw;
			case (hoa)
				XT_FMADDR:  fmaddr  <= wdata.raw[4:0];
				XT_SYSCONF: sysconf <= wdata.raw;
				XT_MEMCONF: memconf <= wdata.raw;
				XT_FDDVIRT: fddvirt <= wdata.raw[3:0];
				XT_INTMASK: intmask <= wdata.raw;
				XT_IM2VECT:
				begin
					// source field picks which vector is loaded
					if (wdata.im2v.source == INT_FRM)
						im2v_frm <= wdata.im2v.vector;
					if (wdata.im2v.source == INT_LIN)
						im2v_lin <= wdata.im2v.vector;
					if (wdata.im2v.source == INT_DMA)
						im2v_dma <= wdata.im2v.vector;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr && memconf[7:6] != 2'd3)  // mode 3 uses bit 5 as page bit
			lock48 <= wdata.p7ffd.lock48;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pwr_up      <= 1'b1;
			pwr_up_flag <= 1'b0;
		end
		else if (stat_rd)
		begin
			pwr_up_flag <= pwr_up;
			pwr_up      <= 1'b0;
		end
	end

	lock48_sticky: assert property (@(posedge clk) disable iff (rst)
		lock48 |=> lock48);

endmodule

`default_nettype wire

//--- src/sd_port.sv
// sd card chip select and spi start
`timescale 1ns/100ps
`default_nettype none

module sd_port
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      acc_stb,
	input  wire                      wr,
	input  wire zports_pkg::port_sel_t sel,
	input  wire [7:0]                wdata,
	output logic                     sdcs_n,
	output logic                     sd_start,
	output logic [7:0]               sd_datain
);

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;  // card deselected
		else if (acc_stb && wr && sel.sdcfg)
			sdcs_n <= wdata[1];
	end

	assign sd_start  = acc_stb & sel.sddat;   // read or write both shift a byte
	assign sd_datain = wr ? wdata : 8'hFF;    // reads clock out ones

endmodule

`default_nettype wire

//--- src/port_read_mux.sv
// port read data select
`timescale 1ns/100ps
`default_nettype none

module port_read_mux
(
	input  wire zports_pkg::port_sel_t sel,
	input  wire [7:0]                hoa,
	input  wire [4:0]                keys_in,
	input  wire                      tape_read,
	input  wire [4:0]                kj_in,
	input  wire [7:0]                sd_dataout,
	input  wire                      pwr_up_flag,
	input  wire [31:0]               xt_page,
	output logic [7:0]               rdata
);

	import zports_pkg::*;

	logic [3:0][7:0] pages;

	assign pages = xt_page;

	always_comb
	begin
		rdata = 8'hFF;  // unmapped and write-only ports

		if (sel.fe)
			rdata = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.kjoy)
			rdata = {3'b000, kj_in};
		else if (sel.sdcfg)
			rdata = 8'h00;  // card present, not write protected
		else if (sel.sddat)
			rdata = sd_dataout;
		else if (sel.xt)
		begin
			case (hoa)
				XT_STATUS:
					rdata = {1'b0, pwr_up_flag, 6'b000000};
				XT_RAMPAGE + 8'd2, XT_RAMPAGE + 8'd3:
					rdata = pages[hoa[1:0]];
				default:
					rdata = 8'hFF;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/zports_top.sv
// zports top level
`timescale 1ns/100ps
`default_nettype none

module zports_top
(
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     req,
	input  wire zports_pkg::cpu_bus_t bus,
	input  wire                     dos,
	input  wire [4:0]               keys_in,
	input  wire                     tape_read,
	input  wire [4:0]               kj_in,
	input  wire [7:0]               sd_dataout,
	output wire                     ack,
	output wire [7:0]               rdata,
	output wire                     porthit,
	output wire [31:0]              xt_page,
	output wire [4:0]               fmaddr,
	output wire [7:0]               sysconf,
	output wire [7:0]               memconf,
	output wire [3:0]               fddvirt,
	output wire [2:0]               im2v_frm,
	output wire [2:0]               im2v_lin,
	output wire [2:0]               im2v_dma,
	output wire [7:0]               intmask,
	output wire                     sdcs_n,
	output wire                     sd_start,
	output wire [7:0]               sd_datain
);

	wire                   acc_stb;
	wire                   pwr_up_flag;
	zports_pkg::port_sel_t sel;

	bus_handshake u_hs (.clk, .rst, .req, .ack, .acc_stb);

	port_decode u_dec (.addr(bus.addr), .dos, .sel, .porthit);

	xt_regs u_xt (.clk, .rst, .acc_stb, .wr(bus.wr), .sel, .hoa(bus.addr[15:8]),
		.wdata(bus.wdata), .xt_page, .fmaddr, .sysconf, .memconf, .fddvirt,
		.im2v_frm, .im2v_lin, .im2v_dma, .intmask, .pwr_up_flag);

	sd_port u_sd (.clk, .rst, .acc_stb, .wr(bus.wr), .sel, .wdata(bus.wdata),
		.sdcs_n, .sd_start, .sd_datain);

	port_read_mux u_rd (.sel, .hoa(bus.addr[15:8]), .keys_in, .tape_read, .kj_in,
		.sd_dataout, .pwr_up_flag, .xt_page, .rdata);

endmodule

`default_nettype wire

//--- verification/zports_tb.sv
// zports port block testbench
`timescale 1ns/100ps
`default_nettype none

module zports_tb;

	localparam int CLK_PERIOD = 100;
	localparam int HS_LIMIT   = 10;  // cycles allowed for each ack edge
	localparam int WD_CYCLES  = 20;  // watchdog budget per table entry

	localparam logic RD      = 1'b0;
	localparam logic WR      = 1'b1;
	localparam logic DOS_OFF = 1'b0;
	localparam logic DOS_ON  = 1'b1;
	localparam logic MISS    = 1'b0;
	localparam logic HIT     = 1'b1;

	// output looked at once the access is over
	localparam logic [3:0] O_NONE = 4'd0;
	localparam logic [3:0] O_PAGE = 4'd1;
	localparam logic [3:0] O_SYSC = 4'd2;
	localparam logic [3:0] O_MEMC = 4'd3;
	localparam logic [3:0] O_INTM = 4'd4;
	localparam logic [3:0] O_FDDV = 4'd5;
	localparam logic [3:0] O_IM2V = 4'd6;  // frm, lin, dma
	localparam logic [3:0] O_SDCS = 4'd7;
	localparam logic [3:0] O_SDIN = 4'd8;
	localparam logic [3:0] O_FMAD = 4'd9;

	typedef struct packed {
		logic        rst_first;
		logic        dos;
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic [7:0]  exp_rd;  // unused on writes
		logic        exp_hit;
		logic [3:0]  obs;
		logic [31:0] obs_exp;
	} test_t;

	logic                 clk;
	logic                 rst;
	logic                 req;
	zports_pkg::cpu_bus_t bus;
	logic                 dos;
	logic [4:0]           keys_in;
	logic                 tape_read;
	logic [4:0]           kj_in;
	logic [7:0]           sd_dataout;
	logic                 ack;
	logic [7:0]           rdata;
	logic                 porthit;
	logic [31:0]          xt_page;
	logic [4:0]           fmaddr;
	logic [7:0]           sysconf;
	logic [7:0]           memconf;
	logic [3:0]           fddvirt;
	logic [2:0]           im2v_frm;
	logic [2:0]           im2v_lin;
	logic [2:0]           im2v_dma;
	logic [7:0]           intmask;
	logic                 sdcs_n;
	logic                 sd_start;
	logic [7:0]           sd_datain;

	test_t tests[$];
	logic  table_ready;
	int    sd_total;  // sd_start pulses seen so far
	int    pass_cnt;
	int    fail_cnt;

	zports_top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
		sd_total = 0;

	always @(negedge clk)
		if (sd_start)
			sd_total++;

	initial
	begin
		wait (table_ready === 1'b1);
		#(tests.size() * WD_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the table was done");
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [31:0] observe(input logic [3:0] code);
		case (code)
			O_PAGE:  return xt_page;
			O_SYSC:  return {24'h0, sysconf};
			O_MEMC:  return {24'h0, memconf};
			O_INTM:  return {24'h0, intmask};
			O_FDDV:  return {28'h0, fddvirt};
			O_IM2V:  return {23'h0, im2v_frm, im2v_lin, im2v_dma};
			O_SDCS:  return {31'h0, sdcs_n};
			O_SDIN:  return {24'h0, sd_datain};
			O_FMAD:  return {27'h0, fmaddr};
			default: return 32'h0;
		endcase
	endfunction

	task automatic add_test(input logic d, input logic [15:0] a, input logic [7:0] wd,
		input logic w, input logic [7:0] exp, input logic hit, input logic [3:0] obs,
		input logic [31:0] oexp);
		test_t t;

		t = '{rst_first: 1'b0, dos: d, addr: a, wdata: wd, wr: w, exp_rd: exp,
			exp_hit: hit, obs: obs, obs_exp: oexp};
		tests.push_back(t);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic compare_value(input int idx, input string what, input logic [31:0] got,
		input logic [31:0] exp, inout logic ok);
		assert (got === exp)
		else
		begin
			$display("Fail at %0t: test %0d %s is %h, expected %h",
				$time, idx, what, got, exp);
			ok = 1'b0;
		end
	endtask

	// one full four-phase access
	task automatic run_access(input int idx, input test_t t, output logic [7:0] rd,
		output logic hit, output int pulses, output logic ok);
		int waited;
		int start_total;

		ok  = 1'b1;
		rd  = 8'h00;
		hit = 1'b0;
		@(posedge clk);
		start_total = sd_total;
		dos <= t.dos;
		bus <= '{addr: t.addr, wdata: t.wdata, wr: t.wr};
		req <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!ack && waited < HS_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
		begin
			$display("test %0d: the DUT never raised ack", idx);
			ok = 1'b0;
		end
		rd  = rdata;  // valid while ack is high
		hit = porthit;
		@(posedge clk);
		req <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (ack && waited < HS_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (ack)
		begin
			$display("test %0d: the DUT kept ack high after req dropped", idx);
			ok = 1'b0;
		end
		pulses = sd_total - start_total;
	endtask

	initial
	begin : main
		logic [31:0] rnd;
		logic [7:0]  rd;
		logic        hit;
		logic        ok;
		int          pulses;
		int          exp_pulses;

		rst         = 1'b1;
		req         = 1'b0;
		bus         = '0;
		dos         = 1'b0;
		table_ready = 1'b0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		rnd         = $urandom(32'h7a2e);
		rnd         = $urandom();
		keys_in     = rnd[4:0];
		tape_read   = rnd[5];
		kj_in       = rnd[12:8];
		sd_dataout  = rnd[23:16];

		// state after reset
		add_test(DOS_OFF, 16'h12AF, 8'h00, RD, 8'h02, HIT, O_PAGE, 32'h0002_0500);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h00, HIT, O_SDCS, 32'h1);
		add_test(DOS_OFF, 16'h00AF, 8'h00, RD, 8'h40, HIT, O_SYSC, 32'h01);
		add_test(DOS_OFF, 16'h00AF, 8'h00, RD, 8'h00, HIT, O_MEMC, 32'h04);
		add_test(DOS_OFF, 16'h10AF, 8'h11, WR, 8'h00, HIT, O_PAGE, 32'h0002_0511);
		add_test(DOS_OFF, 16'h11AF, 8'h22, WR, 8'h00, HIT, O_PAGE, 32'h0002_2211);
		add_test(DOS_OFF, 16'h12AF, 8'h33, WR, 8'h00, HIT, O_PAGE, 32'h0033_2211);
		add_test(DOS_OFF, 16'h13AF, 8'h44, WR, 8'h00, HIT, O_PAGE, 32'h4433_2211);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h44, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h20AF, 8'h5A, WR, 8'h00, HIT, O_SYSC, 32'h5A);
		add_test(DOS_OFF, 16'h2AAF, 8'h0F, WR, 8'h00, HIT, O_INTM, 32'h0F);
		add_test(DOS_OFF, 16'h29AF, 8'h0B, WR, 8'h00, HIT, O_FDDV, 32'h0B);
		add_test(DOS_OFF, 16'h15AF, 8'hF3, WR, 8'h00, HIT, O_FMAD, 32'h13); // low 5 bits
		add_test(DOS_OFF, 16'h25AF, 8'h1A, WR, 8'h00, HIT, O_IM2V, 32'h1E8); // line vector
		add_test(DOS_OFF, 16'h25AF, 8'h04, WR, 8'h00, HIT, O_IM2V, 32'h0A8); // frame vector
		// 7ffd under lock modes 0, 1 and 3
		add_test(DOS_OFF, 16'h21AF, 8'h00, WR, 8'h00, HIT, O_MEMC, 32'h00);
		add_test(DOS_OFF, 16'h7FFD, 8'h95, WR, 8'h00, HIT, O_PAGE, 32'h1533_2211);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h15, HIT, O_MEMC, 32'h01);
		add_test(DOS_OFF, 16'h21AF, 8'h40, WR, 8'h00, HIT, O_MEMC, 32'h40);
		add_test(DOS_OFF, 16'h7FFD, 8'hD6, WR, 8'h00, HIT, O_MEMC, 32'h41);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h06, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h21AF, 8'hC0, WR, 8'h00, HIT, O_MEMC, 32'hC0);
		add_test(DOS_OFF, 16'h7FFD, 8'hA3, WR, 8'h00, HIT, O_MEMC, 32'hC0);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h33, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h7FFD, 8'h01, WR, 8'h00, HIT, O_NONE, 32'h0); // no lock in mode 3
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h01, HIT, O_NONE, 32'h0);
		// 48k lock under mode 0
		add_test(DOS_OFF, 16'h21AF, 8'h00, WR, 8'h00, HIT, O_MEMC, 32'h00);
		add_test(DOS_OFF, 16'h7FFD, 8'h22, WR, 8'h00, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h7FFD, 8'h17, WR, 8'h00, HIT, O_MEMC, 32'h00);
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h02, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h7FFD, 8'h17, WR, 8'h00, HIT, O_PAGE, 32'h0702_0500);
		tests[tests.size() - 1].rst_first = 1'b1;  // reset frees the lock
		add_test(DOS_OFF, 16'h13AF, 8'h00, RD, 8'h07, HIT, O_MEMC, 32'h05);
		// sd card and dos gating
		add_test(DOS_OFF, 16'h0077, 8'hFD, WR, 8'h00, HIT, O_SDCS, 32'h0);
		add_test(DOS_OFF, 16'h0077, 8'h02, WR, 8'h00, HIT, O_SDCS, 32'h1);
		add_test(DOS_OFF, 16'h0077, 8'h00, RD, 8'h00, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h0057, 8'h00, RD, sd_dataout, HIT, O_SDIN, 32'hFF);
		add_test(DOS_OFF, 16'h0057, 8'hA5, WR, 8'h00, HIT, O_SDIN, 32'hA5);
		add_test(DOS_ON, 16'h0077, 8'h00, WR, 8'h00, MISS, O_SDCS, 32'h1);
		add_test(DOS_ON, 16'h0077, 8'h00, RD, 8'hFF, MISS, O_NONE, 32'h0);
		add_test(DOS_ON, 16'h0057, 8'h00, RD, 8'hFF, MISS, O_NONE, 32'h0);
		add_test(DOS_ON, 16'h001F, 8'h00, RD, 8'hFF, MISS, O_NONE, 32'h0);
		// plain read ports
		add_test(DOS_OFF, 16'h00FE, 8'h00, RD, {1'b1, tape_read, 1'b0, keys_in}, HIT,
			O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h001F, 8'h00, RD, {3'b000, kj_in}, HIT, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'hBFFD, 8'h00, RD, 8'hFF, MISS, O_NONE, 32'h0);
		add_test(DOS_OFF, 16'h0033, 8'h00, RD, 8'hFF, MISS, O_NONE, 32'h0);
		table_ready = 1'b1;

		apply_reset();
		foreach (tests[i])
		begin
			if (tests[i].rst_first)
				apply_reset();
			run_access(i, tests[i], rd, hit, pulses, ok);
			exp_pulses = (tests[i].addr[7:0] == 8'h57 && tests[i].dos == DOS_OFF) ? 1 : 0;
			if (tests[i].wr == RD)
				compare_value(i, "rdata", {24'h0, rd}, {24'h0, tests[i].exp_rd}, ok);
			compare_value(i, "porthit", {31'h0, hit}, {31'h0, tests[i].exp_hit}, ok);
			compare_value(i, "sd_start pulse count", pulses, exp_pulses, ok);
			if (tests[i].obs != O_NONE)
				compare_value(i, "output", observe(tests[i].obs), tests[i].obs_exp, ok);
			if (ok)
				pass_cnt++;
			else
				fail_cnt++;
			$display("test %0d %s #%h: %s", i, tests[i].wr ? "write" : "read",
				tests[i].addr, ok ? "ok" : "failed");
		end

		$display("%0d tests, %0d passed, %0d failed", tests.size(), pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
src/zports_pkg.sv
src/bus_handshake.sv
src/port_decode.sv
src/xt_regs.sv
src/sd_port.sv
src/port_read_mux.sv
src/zports_top.sv
verification/zports_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = zports_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
